//--- common/swin_consts.svh
`ifndef SWIN_CONSTS_SVH
`define SWIN_CONSTS_SVH

// Head split geometry
`define SWIN_NUM_HEADS 4

// Width of one beat on every stream
`define SWIN_DATA_WIDTH 16

// Largest block_per_head the counters can hold
`define SWIN_MAX_BLOCK_PER_HEAD 4

// One spare bit so the maximum itself fits
`define SWIN_BPH_WIDTH ($clog2(`SWIN_MAX_BLOCK_PER_HEAD) + 1)

`endif

//--- common/swin_stream_pkg.sv
`include "swin_consts.svh"

package swin_stream_pkg;

  // Bit index of each stream in the packed stream vectors
  typedef enum logic [2:0] {
    STREAM_QUERY_CON = 3'd0,
    STREAM_QUERY_POS = 3'd1,
    STREAM_KEY       = 3'd2,
    STREAM_VALUE     = 3'd3,
    STREAM_POS_EMBED = 3'd4
  } stream_kind_e;

  localparam int unsigned NUM_STREAMS = int'(STREAM_POS_EMBED) + 1;

  typedef logic [`SWIN_DATA_WIDTH-1:0] beat_t;

endpackage

//--- common/swin_cfg_pkg.sv
`include "swin_consts.svh"

package swin_cfg_pkg;

  // Block count or block_per_head value
  typedef logic [`SWIN_BPH_WIDTH-1:0] bph_t;

  typedef enum logic [0:0] {
    CFG_IDLE    = 1'b0,
    CFG_PENDING = 1'b1
  } cfg_state_e;

endpackage

//--- verilog/stream_skid_buffer.sv
`timescale 1ns/1ps

module stream_skid_buffer #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  logic             spill_valid;
  logic [WIDTH-1:0] spill_data;

  // Ready comes straight from a flop
  assign in_ready = ~spill_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid   <= 1'b0;
      spill_valid <= 1'b0;
    end else if (out_ready || !out_valid) begin
      // Main register free or draining
      if (spill_valid) begin
        out_valid   <= 1'b1;
        spill_valid <= 1'b0;
      end else begin
        out_valid <= in_valid;
      end
    end else if (in_valid && in_ready) begin
      // Output stalled, park the beat
      spill_valid <= 1'b1;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (out_ready || !out_valid) begin
      if (spill_valid) begin
        out_data <= spill_data;
      end else if (in_valid) begin
        out_data <= in_data;
      end
    end else if (in_valid && in_ready) begin
      spill_data <= in_data;
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

//--- head_scatter/head_scatter.sv
`timescale 1ns/1ps
`include "swin_consts.svh"

module head_scatter (
  input  logic                                    clk,
  input  logic                                    rst,
  input  swin_cfg_pkg::bph_t                      block_per_head,
  input  logic                                    hold,
  input  logic [swin_stream_pkg::NUM_STREAMS-1:0] s_valid,
  output logic [swin_stream_pkg::NUM_STREAMS-1:0] s_ready,
  output logic [swin_stream_pkg::NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] h_valid,
  input  logic [swin_stream_pkg::NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] h_ready,
  output logic                                    aligned
);

  import swin_stream_pkg::*;
  import swin_cfg_pkg::*;

  localparam int HEAD_W = $clog2(`SWIN_NUM_HEADS);

  logic [NUM_STREAMS-1:0] at_start;

  // Every stream sits at block 0 of head 0
  assign aligned = &at_start;

  for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
    bph_t              block_cnt;
    logic [HEAD_W-1:0] head_cnt;
    logic              gate;
    logic              fire;
    logic              last_block;

    assign at_start[s] = (block_cnt == '0) && (head_cnt == '0);

    // Pending reconfiguration parks the stream at its frame start
    assign gate = hold && at_start[s];

    assign s_ready[s] = h_ready[s][head_cnt] && !gate;
    assign fire       = s_valid[s] && s_ready[s];
    assign last_block = (block_cnt == block_per_head - 1'b1);

    for (genvar h = 0; h < `SWIN_NUM_HEADS; h++) begin : g_head
      assign h_valid[s][h] = s_valid[s] && !gate && (head_cnt == HEAD_W'(h));
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        block_cnt <= '0;
        head_cnt  <= '0;
      end else if (fire) begin
        if (last_block) begin
          block_cnt <= '0;
          head_cnt  <= (head_cnt == HEAD_W'(`SWIN_NUM_HEADS - 1)) ? '0 : head_cnt + 1'b1;
        end else begin
          block_cnt <= block_cnt + 1'b1;
        end
      end
    end

    a_one_head: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(h_valid[s])
    );

    // Holds only because block_per_head changes at a frame boundary
    a_block_range: assert property (
      @(posedge clk) disable iff (rst)
      block_cnt < block_per_head
    );
  end

endmodule

//--- verilog/block_per_head_ctrl.sv
`timescale 1ns/1ps
`include "swin_consts.svh"

module block_per_head_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               cfg_valid,
  input  swin_cfg_pkg::bph_t cfg_block_per_head,
  input  logic               aligned,
  output swin_cfg_pkg::bph_t block_per_head,
  output logic               hold,
  output logic               cfg_busy
);

  import swin_cfg_pkg::*;

  cfg_state_e state;
  bph_t       pending_bph;

  assign hold     = (state == CFG_PENDING);
  assign cfg_busy = (state == CFG_PENDING);

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= CFG_IDLE;
      block_per_head <= bph_t'(`SWIN_MAX_BLOCK_PER_HEAD);
    end else if (cfg_valid) begin
      // A later request overrides the one still waiting
      state <= CFG_PENDING;
    end else if (state == CFG_PENDING && aligned) begin
      state          <= CFG_IDLE;
      block_per_head <= pending_bph;
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_valid) begin
      pending_bph <= cfg_block_per_head;
    end
  end

  a_cfg_range: assert property (
    @(posedge clk) disable iff (rst)
    cfg_valid |-> (cfg_block_per_head >= bph_t'(1)) &&
                  (cfg_block_per_head <= bph_t'(`SWIN_MAX_BLOCK_PER_HEAD))
  );

endmodule

//--- verilog/swin_head_split_top.sv
`timescale 1ns/1ps
`include "swin_consts.svh"

module swin_head_split_top (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [swin_stream_pkg::NUM_STREAMS-1:0] in_valid,
  input  swin_stream_pkg::beat_t [swin_stream_pkg::NUM_STREAMS-1:0] in_data,
  output logic [swin_stream_pkg::NUM_STREAMS-1:0] in_ready,
  output logic [swin_stream_pkg::NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] out_valid,
  output swin_stream_pkg::beat_t [swin_stream_pkg::NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0]
                                                  out_data,
  input  logic [swin_stream_pkg::NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] out_ready,
  input  logic                                    cfg_valid,
  input  swin_cfg_pkg::bph_t                      cfg_block_per_head,
  output logic                                    cfg_busy
);

  import swin_stream_pkg::*;
  import swin_cfg_pkg::*;

  logic  [NUM_STREAMS-1:0]                      s_valid;
  logic  [NUM_STREAMS-1:0]                      s_ready;
  beat_t [NUM_STREAMS-1:0]                      s_data;
  logic  [NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] h_valid;
  logic  [NUM_STREAMS-1:0][`SWIN_NUM_HEADS-1:0] h_ready;
  bph_t                                         block_per_head;
  logic                                         hold;
  logic                                         aligned;

  for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_in
    stream_skid_buffer #(.WIDTH($bits(beat_t))) u_in_skid (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid[s]),
      .in_data  (in_data[s]),
      .in_ready (in_ready[s]),
      .out_valid(s_valid[s]),
      .out_data (s_data[s]),
      .out_ready(s_ready[s])
    );
  end

  block_per_head_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .cfg_valid         (cfg_valid),
    .cfg_block_per_head(cfg_block_per_head),
    .aligned           (aligned),
    .block_per_head    (block_per_head),
    .hold              (hold),
    .cfg_busy          (cfg_busy)
  );

  head_scatter u_scatter (
    .clk           (clk),
    .rst           (rst),
    .block_per_head(block_per_head),
    .hold          (hold),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .h_valid       (h_valid),
    .h_ready       (h_ready),
    .aligned       (aligned)
  );

  // Beat data fans out to every head, h_valid picks the receiver
  for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_out_stream
    for (genvar h = 0; h < `SWIN_NUM_HEADS; h++) begin : g_out_head
      stream_skid_buffer #(.WIDTH($bits(beat_t))) u_out_skid (
        .clk      (clk),
        .rst      (rst),
        .in_valid (h_valid[s][h]),
        .in_data  (s_data[s]),
        .in_ready (h_ready[s][h]),
        .out_valid(out_valid[s][h]),
        .out_data (out_data[s][h]),
        .out_ready(out_ready[s][h])
      );
    end
  end

endmodule

//--- tests/swin_head_split_tb.sv
`timescale 1ns/1ps
`include "swin_consts.svh"

module swin_head_split_tb;

  import swin_stream_pkg::*;
  import swin_cfg_pkg::*;

  localparam int NUM_HEADS   = `SWIN_NUM_HEADS;
  localparam int SEQ_W       = `SWIN_DATA_WIDTH - 3;
  localparam int CLK_PERIOD  = 4;
  localparam int MAP_DEPTH   = 256;
  localparam int WAIT_LIMIT  = 200;
  // Beats per stream summed over the five tests
  localparam int TOTAL_BEATS = NUM_STREAMS * (32 + 32 + 48 + 24 + 28);
  localparam int WATCHDOG_NS = TOTAL_BEATS * 8 * CLK_PERIOD + 2000;

  logic                                   clk;
  logic                                   rst;
  logic  [NUM_STREAMS-1:0]                in_valid;
  beat_t [NUM_STREAMS-1:0]                in_data;
  logic  [NUM_STREAMS-1:0]                in_ready;
  logic  [NUM_STREAMS-1:0][NUM_HEADS-1:0] out_valid;
  beat_t [NUM_STREAMS-1:0][NUM_HEADS-1:0] out_data;
  logic  [NUM_STREAMS-1:0][NUM_HEADS-1:0] out_ready;
  logic  [NUM_STREAMS-1:0][NUM_HEADS-1:0] ready_mask;
  logic                                   cfg_valid;
  bph_t                                   cfg_block_per_head;
  logic                                   cfg_busy;

  // Driver and reference model state per stream
  int          issued[NUM_STREAMS];
  int          accepted[NUM_STREAMS];
  int          target[NUM_STREAMS];
  int          frame_pos[NUM_STREAMS];
  int          model_bph[NUM_STREAMS];
  int          next_bph[NUM_STREAMS];
  int          head_of[NUM_STREAMS][MAP_DEPTH];
  beat_t       exp_q[NUM_STREAMS][NUM_HEADS][$];
  logic [31:0] rng_state;
  logic        rand_ready;
  int          gap_pct;

  swin_head_split_top DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int pending_beats(input int s);
    int n = 0;
    int h;
    for (h = 0; h < NUM_HEADS; h++)
      n += exp_q[s][h].size();
    return n;
  endfunction

  function automatic logic all_accepted();
    int s;
    for (s = 0; s < NUM_STREAMS; s++)
      if (accepted[s] != target[s])
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t got);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s expected 0x%h, actual 0x%h",
                          $time, name, exp, got));
  endtask

  task automatic check_head(input string name, input int exp, input int got);
    if (got != exp)
      abort_run($sformatf("** Error at %0t: %s expected %0d, actual %0d",
                          $time, name, exp, got));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s expected %b, actual %b",
                          $time, name, exp, got));
  endtask

  // The beat's place in its frame picks the head
  task automatic issue_beat(input int s);
    int    h;
    beat_t b;
    h = (frame_pos[s] / model_bph[s]) % NUM_HEADS;
    b = beat_t'((s << SEQ_W) | issued[s]);
    head_of[s][issued[s]] = h;
    exp_q[s][h].push_back(b);
    in_valid[s] <= 1'b1;
    in_data[s]  <= b;
    issued[s]++;
    frame_pos[s]++;
    if (frame_pos[s] == model_bph[s] * NUM_HEADS) begin
      frame_pos[s] = 0;
      if (next_bph[s] != 0) begin
        model_bph[s] = next_bph[s];
        next_bph[s]  = 0;
      end
    end
  endtask

  task automatic drive_cycle();
    int s;
    int h;
    @(posedge clk);
    for (s = 0; s < NUM_STREAMS; s++)
      if (in_valid[s] && in_ready[s])
        accepted[s]++;
    for (s = 0; s < NUM_STREAMS; s++)
      for (h = 0; h < NUM_HEADS; h++)
        out_ready[s][h] <= rand_ready ? (xorshift32() % 4 != 0) : ready_mask[s][h];
    for (s = 0; s < NUM_STREAMS; s++) begin
      // A beat not yet taken stays on the bus
      if (!in_valid[s] || in_ready[s]) begin
        if (issued[s] < target[s] && xorshift32() % 100 >= gap_pct)
          issue_beat(s);
        else
          in_valid[s] <= 1'b0;
      end
    end
  endtask

  task automatic send_frames(input int beats);
    int s;
    for (s = 0; s < NUM_STREAMS; s++)
      target[s] += beats;
    while (!all_accepted())
      drive_cycle();
  endtask

  task automatic drain_outputs();
    int s;
    int cyc;
    int left;
    left = 1;
    for (cyc = 0; cyc < WAIT_LIMIT && left != 0; cyc++) begin
      drive_cycle();
      left = 0;
      for (s = 0; s < NUM_STREAMS; s++)
        left += pending_beats(s);
    end
    for (s = 0; s < NUM_STREAMS; s++)
      if (pending_beats(s) != 0)
        abort_run($sformatf("Stream %0d lost beats, %0d never reached a head output",
                            s, pending_beats(s)));
  endtask

  task automatic program_bph(input int bph);
    int s;
    drive_cycle();
    cfg_valid          <= 1'b1;
    cfg_block_per_head <= bph_t'(bph);
    // Streams mid-frame switch at their own next frame start
    for (s = 0; s < NUM_STREAMS; s++)
      if (frame_pos[s] == 0)
        model_bph[s] = bph;
      else
        next_bph[s] = bph;
    drive_cycle();
    cfg_valid <= 1'b0;
    drive_cycle();
    check_flag("cfg_busy", 1'b1, cfg_busy);
  endtask

  task automatic wait_cfg_idle();
    int cyc;
    for (cyc = 0; cyc < WAIT_LIMIT && cfg_busy; cyc++)
      drive_cycle();
    if (cfg_busy)
      abort_run("cfg_busy stayed high after every stream reached a frame boundary");
  endtask

  task automatic check_output(input int s, input int h, input beat_t got);
    beat_t exp;
    if (exp_q[s][h].size() == 0)
      abort_run($sformatf("Stream %0d head %0d delivered beat 0x%h that was never sent",
                          s, h, got));
    check_head($sformatf("out_valid[%0d] head index", s),
               head_of[s][got[SEQ_W-1:0] % MAP_DEPTH], h);
    exp = exp_q[s][h].pop_front();
    check_beat($sformatf("out_data[%0d][%0d]", s, h), exp, got);
  endtask

  for (genvar gs = 0; gs < NUM_STREAMS; gs++) begin : g_mon_stream
    for (genvar gh = 0; gh < NUM_HEADS; gh++) begin : g_mon_head
      always @(posedge clk) begin
        if (!rst && out_valid[gs][gh] && out_ready[gs][gh])
          check_output(gs, gh, out_data[gs][gh]);
      end
    end
  end

  task automatic test_head_stall();
    int   s;
    int   cyc;
    logic others_done;
    ready_mask                = '1;
    ready_mask[STREAM_KEY][1] = 1'b0;
    for (s = 0; s < NUM_STREAMS; s++)
      target[s] += 2 * 3 * NUM_HEADS;
    others_done = 1'b0;
    for (cyc = 0; cyc < WAIT_LIMIT && !others_done; cyc++) begin
      drive_cycle();
      others_done = 1'b1;
      for (s = 0; s < NUM_STREAMS; s++)
        if (s != int'(STREAM_KEY) && (accepted[s] != target[s] || pending_beats(s) != 0))
          others_done = 1'b0;
    end
    if (!others_done)
      abort_run("Other streams stopped while one key head was held off");
    if (accepted[STREAM_KEY] == target[STREAM_KEY] || exp_q[STREAM_KEY][1].size() == 0)
      abort_run("Key stream kept flowing past its stalled head");
    ready_mask = '1;
    while (!all_accepted())
      drive_cycle();
    drain_outputs();
  endtask

  task automatic test_reprogram_skewed();
    int   s;
    int   base[NUM_STREAMS];
    logic old_open;
    for (s = 0; s < NUM_STREAMS; s++) begin
      base[s]    = accepted[s];
      target[s] += 2 + 2 * s;
    end
    while (!all_accepted())
      drive_cycle();
    program_bph(2);
    for (s = 0; s < NUM_STREAMS; s++)
      target[s] += 3 * NUM_HEADS - (2 + 2 * s) + 2 * 2 * NUM_HEADS;
    while (!all_accepted()) begin
      drive_cycle();
      old_open = 1'b0;
      for (s = 0; s < NUM_STREAMS; s++)
        if (accepted[s] - base[s] < 3 * NUM_HEADS)
          old_open = 1'b1;
      if (old_open)
        check_flag("cfg_busy", 1'b1, cfg_busy);
    end
    wait_cfg_idle();
    drain_outputs();
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the tests completed");
  end

  initial begin : main_seq
    int s;
    int i;
    clk                = 1'b0;
    rst                = 1'b1;
    in_valid           = '0;
    in_data            = '0;
    out_ready          = '1;
    ready_mask         = '1;
    cfg_valid          = 1'b0;
    cfg_block_per_head = '0;
    rng_state          = 32'hb632_c8ec;
    rand_ready         = 1'b0;
    gap_pct            = 0;
    for (s = 0; s < NUM_STREAMS; s++) begin
      model_bph[s] = `SWIN_MAX_BLOCK_PER_HEAD;
      for (i = 0; i < MAP_DEPTH; i++)
        head_of[s][i] = -1;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Reset value of block_per_head
    send_frames(2 * `SWIN_MAX_BLOCK_PER_HEAD * NUM_HEADS);
    drain_outputs();

    // Reprogram while idle
    program_bph(1);
    wait_cfg_idle();
    send_frames(2 * 1 * NUM_HEADS);
    drain_outputs();
    program_bph(3);
    wait_cfg_idle();
    send_frames(2 * 3 * NUM_HEADS);
    drain_outputs();

    // Random back-pressure and input gaps
    rand_ready = 1'b1;
    gap_pct    = 30;
    send_frames(4 * 3 * NUM_HEADS);
    rand_ready = 1'b0;
    gap_pct    = 0;
    drain_outputs();

    test_head_stall();
    test_reprogram_skewed();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/swin_stream_pkg.sv
common/swin_cfg_pkg.sv
verilog/stream_skid_buffer.sv
head_scatter/head_scatter.sv
verilog/block_per_head_ctrl.sv
verilog/swin_head_split_top.sv
tests/swin_head_split_tb.sv

//--- Bender.yml
package:
  name: swin_head_split

export_include_dirs:
  - common

sources:
  - files:
      - common/swin_stream_pkg.sv
      - common/swin_cfg_pkg.sv
      - verilog/stream_skid_buffer.sv
      - head_scatter/head_scatter.sv
      - verilog/block_per_head_ctrl.sv
      - verilog/swin_head_split_top.sv
  - target: test
    files:
      - tests/swin_head_split_tb.sv
